//--- design/csr_pkg.sv
// Shared widths, types and register map of the CSR subsystem.
// Imported by the AXI bridge, the register file, both interfaces and the testbench.

`default_nettype none

package csr_pkg;

   // --------------------
   // Widths
   // --------------------
   localparam int ADDR_WIDTH  = 16;
   localparam int DATA_WIDTH  = 64;
   localparam int ID_WIDTH    = 4;
   localparam int STRB_WIDTH  = DATA_WIDTH / 8;
   localparam int LEN_WIDTH   = 8;
   localparam int SIZE_WIDTH  = 3;
   localparam int BURST_WIDTH = 2;

   typedef logic [ADDR_WIDTH-1:0]  addr_t;
   typedef logic [DATA_WIDTH-1:0]  data_t;
   typedef logic [STRB_WIDTH-1:0]  strb_t;
   typedef logic [ID_WIDTH-1:0]    tid_t;
   typedef logic [LEN_WIDTH-1:0]   axlen_t;
   typedef logic [SIZE_WIDTH-1:0]  axsize_t;
   typedef logic [BURST_WIDTH-1:0] axburst_t;

   // AXI field encodings the bridge accepts
   localparam axsize_t  AXSIZE_4B   = 3'b010;
   localparam axsize_t  AXSIZE_8B   = 3'b011;
   localparam axburst_t BURST_FIXED = 2'b00;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } resp_t;

   typedef enum logic [1:0] {
      FULL64  = 2'b00,
      LOWER32 = 2'b01,
      UPPER32 = 2'b10
   } csr_access_type_t;

   // --------------------
   // Register map
   // --------------------
   localparam addr_t CSR_ID_ADDR       = 16'h0000;
   localparam addr_t CSR_SCRATCH0_ADDR = 16'h0008;
   localparam addr_t CSR_SCRATCH1_ADDR = 16'h0010;
   localparam data_t CSR_ID_VALUE      = 64'h0001_0002_c5a0_0001;

   // Byte lanes covered by each access type
   function automatic strb_t lane_strb(input csr_access_type_t access);
      case (access)
         LOWER32: return 8'h0f;
         UPPER32: return 8'hf0;
         default: return 8'hff;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- design/axi_mmio_if.sv
// AXI-4 MMIO signal bundle between the top level and the CSR bridge.
// The manager modport drives requests, the subordinate modport answers them.

`timescale 1ns/100ps
`default_nettype none

interface axi_mmio_if;
   import csr_pkg::*;

   // Write address, data and response
   logic     awvalid, awready;
   tid_t     awid;
   addr_t    awaddr;
   axlen_t   awlen;
   axsize_t  awsize;
   axburst_t awburst;
   logic     wvalid, wready, wlast;
   data_t    wdata;
   strb_t    wstrb;
   logic     bvalid, bready;
   tid_t     bid;
   resp_t    bresp;

   // Read address and data
   logic     arvalid, arready;
   tid_t     arid;
   addr_t    araddr;
   axlen_t   arlen;
   axsize_t  arsize;
   axburst_t arburst;
   logic     rvalid, rready, rlast;
   tid_t     rid;
   data_t    rdata;
   resp_t    rresp;

   modport manager (
      output awvalid, awid, awaddr, awlen, awsize, awburst, wvalid, wdata, wstrb, wlast,
      output bready, arvalid, arid, araddr, arlen, arsize, arburst, rready,
      input  awready, wready, bvalid, bid, bresp, arready, rvalid, rid, rdata, rresp, rlast
   );

   modport subordinate (
      input  awvalid, awid, awaddr, awlen, awsize, awburst, wvalid, wdata, wstrb, wlast,
      input  bready, arvalid, arid, araddr, arlen, arsize, arburst, rready,
      output awready, wready, bvalid, bid, bresp, arready, rvalid, rid, rdata, rresp, rlast
   );

endinterface

`default_nettype wire

//--- design/csr_bus_if.sv
// CSR strobe bus from the AXI bridge to the register file.
// Write and read are single-cycle strobes, read data returns one cycle later.

`timescale 1ns/100ps
`default_nettype none

interface csr_bus_if;
   import csr_pkg::*;

   logic             csr_write;
   addr_t            waddr;
   csr_access_type_t write_type;
   data_t            wdata;
   strb_t            wstrb;

   logic             csr_read;
   addr_t            raddr;
   logic             read_32b;
   data_t            readdata;
   logic             readdata_valid;

   modport bridge (
      output csr_write, waddr, write_type, wdata, wstrb, csr_read, raddr, read_32b,
      input  readdata, readdata_valid
   );

   modport regfile (
      input  csr_write, waddr, write_type, wdata, wstrb, csr_read, raddr, read_32b,
      output readdata, readdata_valid
   );

endinterface

`default_nettype wire

//--- design/axi_csr_slave.sv
// AXI-4 to CSR bridge for single-beat 4-byte and 8-byte accesses.
// Each accepted request becomes one CSR write or read strobe; illegal
// requests are answered with SLVERR and never reach the register file.

`timescale 1ns/100ps
`default_nettype none

module axi_csr_slave (
   axi_mmio_if.subordinate csr_if,
   csr_bus_if.bridge       csr_bus,
   input wire              clk,
   input wire              rst_n
);
   import csr_pkg::*;

   typedef enum logic [3:0] {
      WR_IDLE = 4'b0001,
      WR_DATA = 4'b0010,
      WR_CSR  = 4'b0100,
      WR_RESP = 4'b1000
   } wr_state_t;

   typedef enum logic [3:0] {
      RD_IDLE = 4'b0001,
      RD_CSR  = 4'b0010,
      RD_WAIT = 4'b0100,
      RD_RESP = 4'b1000
   } rd_state_t;

   // Only fixed bursts of 4 or 8 bytes
   function automatic logic burst_size_err(input axburst_t burst, input axsize_t size);
      return (burst != BURST_FIXED) || !(size == AXSIZE_4B || size == AXSIZE_8B);
   endfunction

   function automatic logic align_err(input addr_t addr, input axsize_t size);
      return (|addr[1:0]) || (size == AXSIZE_8B && addr[2]);
   endfunction

   function automatic csr_access_type_t access_type(input addr_t addr, input axsize_t size);
      if (size == AXSIZE_4B) begin
         return addr[2] ? UPPER32 : LOWER32;
      end
      return FULL64;
   endfunction

   wr_state_t wr_state, wr_state_next;
   rd_state_t rd_state, rd_state_next;

   logic  awready_q, awready_next;
   logic  wready_q, wready_next;
   logic  bvalid_q, bvalid_next;
   logic  csr_write_next;
   logic  aw_xfer, w_xfer, b_xfer;
   tid_t  awid_q;
   logic  aw_burst_err, aw_len_err, aw_addr_err;
   logic  aw_legal;
   logic  wstrb_ok;

   logic  arready_q, arready_next;
   logic  rvalid_q, rvalid_next;
   logic  csr_read_next;
   logic  ar_xfer, r_xfer;
   tid_t  arid_q;
   logic  ar_burst_err_d, ar_len_err_d, ar_addr_err_d;
   logic  ar_burst_err, ar_len_err, ar_addr_err;
   logic  ar_legal;
   data_t rdata_q;

   assign aw_xfer = csr_if.awvalid && awready_q;
   assign w_xfer  = csr_if.wvalid && wready_q;
   assign b_xfer  = bvalid_q && csr_if.bready;
   assign ar_xfer = csr_if.arvalid && arready_q;
   assign r_xfer  = rvalid_q && csr_if.rready;

   assign csr_if.awready = awready_q;
   assign csr_if.wready  = wready_q;
   assign csr_if.bvalid  = bvalid_q;
   assign csr_if.bid     = awid_q;
   assign csr_if.bresp   = aw_legal ? RESP_OKAY : RESP_SLVERR;

   assign csr_if.arready = arready_q;
   assign csr_if.rvalid  = rvalid_q;
   assign csr_if.rlast   = rvalid_q;
   assign csr_if.rid     = arid_q;
   assign csr_if.rdata   = rdata_q;
   assign csr_if.rresp   = ar_legal ? RESP_OKAY : RESP_SLVERR;

   // --------------------
   // Write path
   // --------------------
   assign aw_legal = !(aw_burst_err || aw_len_err || aw_addr_err);
   assign wstrb_ok = (csr_if.wstrb == lane_strb(csr_bus.write_type));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_state          <= WR_IDLE;
         awready_q         <= 1'b0;
         wready_q          <= 1'b0;
         bvalid_q          <= 1'b0;
         csr_bus.csr_write <= 1'b0;
      end else begin
         wr_state          <= wr_state_next;
         awready_q         <= awready_next;
         wready_q          <= wready_next;
         bvalid_q          <= bvalid_next;
         csr_bus.csr_write <= csr_write_next;
      end
   end

   always_comb begin
      wr_state_next  = wr_state;
      awready_next   = 1'b0;
      wready_next    = 1'b0;
      bvalid_next    = 1'b0;
      csr_write_next = 1'b0;
      case (wr_state)
         WR_IDLE: begin
            if (aw_xfer) begin
               wready_next   = 1'b1;
               wr_state_next = WR_DATA;
            end else begin
               awready_next = 1'b1;
            end
         end
         WR_DATA: begin
            if (w_xfer) begin
               // Strobe mismatch drops the write but not the response
               csr_write_next = aw_legal && wstrb_ok && csr_if.wlast;
               bvalid_next    = 1'b1;
               wr_state_next  = WR_CSR;
            end else begin
               wready_next = 1'b1;
            end
         end
         WR_CSR, WR_RESP: begin
            if (b_xfer) begin
               awready_next  = 1'b1;
               wr_state_next = WR_IDLE;
            end else begin
               bvalid_next   = 1'b1;
               wr_state_next = WR_RESP;
            end
         end
         default: wr_state_next = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (aw_xfer) begin
         awid_q             <= csr_if.awid;
         csr_bus.waddr      <= csr_if.awaddr;
         csr_bus.write_type <= access_type(csr_if.awaddr, csr_if.awsize);
         aw_burst_err       <= burst_size_err(csr_if.awburst, csr_if.awsize);
         aw_len_err         <= |csr_if.awlen;
         aw_addr_err        <= align_err(csr_if.awaddr, csr_if.awsize);
      end
      if (w_xfer) begin
         csr_bus.wdata <= csr_if.wdata;
         csr_bus.wstrb <= csr_if.wstrb;
      end
   end

   // --------------------
   // Read path
   // --------------------
   assign ar_burst_err_d = burst_size_err(csr_if.arburst, csr_if.arsize);
   assign ar_len_err_d   = |csr_if.arlen;
   assign ar_addr_err_d  = align_err(csr_if.araddr, csr_if.arsize);
   assign ar_legal       = !(ar_burst_err || ar_len_err || ar_addr_err);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_state         <= RD_IDLE;
         arready_q        <= 1'b0;
         rvalid_q         <= 1'b0;
         csr_bus.csr_read <= 1'b0;
      end else begin
         rd_state         <= rd_state_next;
         arready_q        <= arready_next;
         rvalid_q         <= rvalid_next;
         csr_bus.csr_read <= csr_read_next;
      end
   end

   always_comb begin
      rd_state_next = rd_state;
      arready_next  = 1'b0;
      rvalid_next   = 1'b0;
      csr_read_next = 1'b0;
      case (rd_state)
         RD_IDLE: begin
            if (ar_xfer) begin
               // Read strobe goes out with the checks on the live request
               csr_read_next = !(ar_burst_err_d || ar_len_err_d || ar_addr_err_d);
               rd_state_next = RD_CSR;
            end else begin
               arready_next = 1'b1;
            end
         end
         RD_CSR: begin
            if (ar_legal) begin
               rd_state_next = RD_WAIT;
            end else begin
               rvalid_next   = 1'b1;
               rd_state_next = RD_RESP;
            end
         end
         RD_WAIT: begin
            if (csr_bus.readdata_valid) begin
               rvalid_next   = 1'b1;
               rd_state_next = RD_RESP;
            end
         end
         RD_RESP: begin
            if (r_xfer) begin
               arready_next  = 1'b1;
               rd_state_next = RD_IDLE;
            end else begin
               rvalid_next = 1'b1;
            end
         end
         default: rd_state_next = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (ar_xfer) begin
         arid_q           <= csr_if.arid;
         csr_bus.raddr    <= csr_if.araddr;
         csr_bus.read_32b <= (csr_if.arsize == AXSIZE_4B);
         ar_burst_err     <= ar_burst_err_d;
         ar_len_err       <= ar_len_err_d;
         ar_addr_err      <= ar_addr_err_d;
      end
      // Illegal read answers with zero data
      if (rd_state == RD_CSR && !ar_legal) begin
         rdata_q <= '0;
      end else if (rd_state == RD_WAIT && csr_bus.readdata_valid) begin
         rdata_q <= csr_bus.readdata;
      end
   end

endmodule

`default_nettype wire

//--- design/csr_regfile.sv
// CSR register file with a read-only ID and two 64-bit scratch registers.
// Writes land in one cycle with byte strobes, reads return one cycle after the strobe.

`timescale 1ns/100ps
`default_nettype none

module csr_regfile (
   input wire          clk,
   input wire          rst_n,
   csr_bus_if.regfile  csr_bus
);
   import csr_pkg::*;

   data_t scratch0;
   data_t scratch1;
   addr_t wsel_addr;
   addr_t rsel_addr;
   data_t rd_value;

   // Byte-wise merge of new data into a register
   function automatic data_t merge_bytes(input data_t cur, input data_t wr_val, input strb_t be);
      data_t result;
      result = cur;
      for (int i = 0; i < STRB_WIDTH; i++) begin
         if (be[i]) begin
            result[i*8 +: 8] = wr_val[i*8 +: 8];
         end
      end
      return result;
   endfunction

   // Registers are 8-byte aligned, bit 2 only picks the lane
   assign wsel_addr = {csr_bus.waddr[ADDR_WIDTH-1:3], 3'b000};
   assign rsel_addr = {csr_bus.raddr[ADDR_WIDTH-1:3], 3'b000};

   // --------------------
   // Write side
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch0 <= '0;
         scratch1 <= '0;
      end else if (csr_bus.csr_write) begin
         if (wsel_addr == CSR_SCRATCH0_ADDR) begin
            scratch0 <= merge_bytes(scratch0, csr_bus.wdata, csr_bus.wstrb);
         end
         if (wsel_addr == CSR_SCRATCH1_ADDR) begin
            scratch1 <= merge_bytes(scratch1, csr_bus.wdata, csr_bus.wstrb);
         end
      end
   end

   // --------------------
   // Read side
   // --------------------
   always_comb begin
      case (rsel_addr)
         CSR_ID_ADDR:       rd_value = CSR_ID_VALUE;
         CSR_SCRATCH0_ADDR: rd_value = scratch0;
         CSR_SCRATCH1_ADDR: rd_value = scratch1;
         default:           rd_value = '0;
      endcase
      // Lower-lane 32-bit read clears the upper half; upper lane gets the whole word
      if (csr_bus.read_32b && !csr_bus.raddr[2]) begin
         rd_value[DATA_WIDTH-1:DATA_WIDTH/2] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_bus.readdata_valid <= 1'b0;
      end else begin
         csr_bus.readdata_valid <= csr_bus.csr_read;
      end
   end

   always_ff @(posedge clk) begin
      if (csr_bus.csr_read) begin
         csr_bus.readdata <= rd_value;
      end
   end

endmodule

`default_nettype wire

//--- design/csr_subsystem_top.sv
// Top level of the CSR subsystem with plain AXI-4 subordinate ports.
// The ports are packed into the MMIO interface that feeds the AXI bridge,
// with the register file behind the bridge.

`timescale 1ns/100ps
`default_nettype none

module csr_subsystem_top (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                awvalid,
   output logic               awready,
   input  wire csr_pkg::tid_t     awid,
   input  wire csr_pkg::addr_t    awaddr,
   input  wire csr_pkg::axlen_t   awlen,
   input  wire csr_pkg::axsize_t  awsize,
   input  wire csr_pkg::axburst_t awburst,
   input  wire                wvalid,
   output logic               wready,
   input  wire csr_pkg::data_t    wdata,
   input  wire csr_pkg::strb_t    wstrb,
   input  wire                wlast,
   output logic               bvalid,
   input  wire                bready,
   output csr_pkg::tid_t      bid,
   output csr_pkg::resp_t     bresp,
   input  wire                arvalid,
   output logic               arready,
   input  wire csr_pkg::tid_t     arid,
   input  wire csr_pkg::addr_t    araddr,
   input  wire csr_pkg::axlen_t   arlen,
   input  wire csr_pkg::axsize_t  arsize,
   input  wire csr_pkg::axburst_t arburst,
   output logic               rvalid,
   input  wire                rready,
   output csr_pkg::tid_t      rid,
   output csr_pkg::data_t     rdata,
   output csr_pkg::resp_t     rresp,
   output logic               rlast
);

   axi_mmio_if mmio_if ();
   csr_bus_if  csr_bus ();

   // Manager side of the bundle comes from the ports
   assign mmio_if.awvalid = awvalid;
   assign mmio_if.awid    = awid;
   assign mmio_if.awaddr  = awaddr;
   assign mmio_if.awlen   = awlen;
   assign mmio_if.awsize  = awsize;
   assign mmio_if.awburst = awburst;
   assign mmio_if.wvalid  = wvalid;
   assign mmio_if.wdata   = wdata;
   assign mmio_if.wstrb   = wstrb;
   assign mmio_if.wlast   = wlast;
   assign mmio_if.bready  = bready;
   assign mmio_if.arvalid = arvalid;
   assign mmio_if.arid    = arid;
   assign mmio_if.araddr  = araddr;
   assign mmio_if.arlen   = arlen;
   assign mmio_if.arsize  = arsize;
   assign mmio_if.arburst = arburst;
   assign mmio_if.rready  = rready;

   assign awready = mmio_if.awready;
   assign wready  = mmio_if.wready;
   assign bvalid  = mmio_if.bvalid;
   assign bid     = mmio_if.bid;
   assign bresp   = mmio_if.bresp;
   assign arready = mmio_if.arready;
   assign rvalid  = mmio_if.rvalid;
   assign rid     = mmio_if.rid;
   assign rdata   = mmio_if.rdata;
   assign rresp   = mmio_if.rresp;
   assign rlast   = mmio_if.rlast;

   axi_csr_slave i_axi_csr_slave (
      .csr_if  (mmio_if.subordinate),
      .csr_bus (csr_bus.bridge),
      .clk     (clk),
      .rst_n   (rst_n)
   );

   csr_regfile i_csr_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .csr_bus (csr_bus.regfile)
   );

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
// Testbench clock and reset source.
// Makes a 100 ns clock and holds rst_n low over the first two rising edges.

`timescale 1ns/100ps
`default_nettype none

module clk_gen (
   output logic clk,
   output logic rst_n
);

   // Half period of 50 ns
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Released on a falling edge, away from the DUT sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/tb_csr_subsystem.sv
// Testbench for the CSR subsystem.
// Replays the transactions of verif/csr_golden.txt over the AXI ports, with random
// stalls on bready and rready, and checks responses, IDs and read data.

`timescale 1ns/100ps
`default_nettype none

module tb_csr_subsystem;
   import csr_pkg::*;

   typedef struct packed {
      logic [7:0] op;
      tid_t       id;
      addr_t      addr;
      axsize_t    size;
      axlen_t     len;
      axburst_t   burst;
      strb_t      strb;
      data_t      wdata;
      resp_t      resp;
      data_t      rdata;
   } txn_t;

   logic     clk;
   logic     rst_n;
   logic     awvalid, awready;
   tid_t     awid;
   addr_t    awaddr;
   axlen_t   awlen;
   axsize_t  awsize;
   axburst_t awburst;
   logic     wvalid, wready, wlast;
   data_t    wdata;
   strb_t    wstrb;
   logic     bvalid, bready;
   tid_t     bid;
   resp_t    bresp;
   logic     arvalid, arready;
   tid_t     arid;
   addr_t    araddr;
   axlen_t   arlen;
   axsize_t  arsize;
   axburst_t arburst;
   logic     rvalid, rready, rlast;
   tid_t     rid;
   data_t    rdata;
   resp_t    rresp;

   txn_t        txns[$];
   int          errors = 0;
   int unsigned cycle_cnt = 0;
   int unsigned cycle_limit = 100;
   logic [31:0] lfsr_state = 32'hfb14_2ac7;

   clk_gen i_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   csr_subsystem_top i_csr_subsystem_top (.*);

   // --------------------
   // Helpers
   // --------------------
   function automatic logic [31:0] galois_step(input logic [31:0] s);
      if (s[0]) begin
         return {1'b0, s[31:1]} ^ 32'h8020_0003;
      end
      return {1'b0, s[31:1]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = galois_step(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      errors++;
   endtask

   task automatic init_inputs();
      awvalid = 1'b0;
      awid    = '0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = '0;
      awburst = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wlast   = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      arid    = '0;
      araddr  = '0;
      arlen   = '0;
      arsize  = '0;
      arburst = '0;
      rready  = 1'b0;
   endtask

   task automatic load_golden();
      int          fd;
      int          count;
      int          line_no;
      string       line_str;
      logic [7:0]  f_op;
      logic [31:0] f_id, f_addr, f_size, f_len, f_burst, f_strb, f_resp;
      logic [63:0] f_wdata, f_rdata;
      txn_t        t;
      line_no = 0;
      fd = $fopen("verif/csr_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file verif/csr_golden.txt");
         errors++;
         return;
      end
      while ($fgets(line_str, fd) != 0) begin
         line_no++;
         // Comment and empty lines
         if (line_str.len() < 2 || line_str[0] == "#") begin
            continue;
         end
         count = $sscanf(line_str, "%c %h %h %h %h %h %h %h %h %h", f_op, f_id, f_addr,
                         f_size, f_len, f_burst, f_strb, f_wdata, f_resp, f_rdata);
         if (count != 10) begin
            $display("Golden file line %0d could not be parsed", line_no);
            errors++;
         end else begin
            t.op    = f_op;
            t.id    = f_id[ID_WIDTH-1:0];
            t.addr  = f_addr[ADDR_WIDTH-1:0];
            t.size  = f_size[SIZE_WIDTH-1:0];
            t.len   = f_len[LEN_WIDTH-1:0];
            t.burst = f_burst[BURST_WIDTH-1:0];
            t.strb  = f_strb[STRB_WIDTH-1:0];
            t.wdata = f_wdata;
            t.resp  = resp_t'(f_resp[1:0]);
            t.rdata = f_rdata;
            txns.push_back(t);
         end
      end
      $fclose(fd);
      // Worst case per transaction stays well below 40 cycles
      cycle_limit = txns.size() * 40 + 100;
   endtask

   task automatic check_reset();
      repeat (2) begin
         @(negedge clk);
         if (awready !== 1'b0) report_mismatch("awready", 64'(awready), 64'(0));
         if (arready !== 1'b0) report_mismatch("arready", 64'(arready), 64'(0));
         if (wready !== 1'b0) report_mismatch("wready", 64'(wready), 64'(0));
         if (bvalid !== 1'b0) report_mismatch("bvalid", 64'(bvalid), 64'(0));
         if (rvalid !== 1'b0) report_mismatch("rvalid", 64'(rvalid), 64'(0));
      end
      // One cycle after release both address channels are ready
      @(negedge clk);
      if (awready !== 1'b1) report_mismatch("awready", 64'(awready), 64'(1));
      if (arready !== 1'b1) report_mismatch("arready", 64'(arready), 64'(1));
   endtask

   // --------------------
   // AXI transactions
   // --------------------
   task automatic run_write(input txn_t t);
      tid_t        got_id;
      resp_t       got_resp;
      logic [31:0] stall;
      stall = random_bits(2);
      @(negedge clk);
      awvalid = 1'b1;
      awid    = t.id;
      awaddr  = t.addr;
      awlen   = t.len;
      awsize  = t.size;
      awburst = t.burst;
      while (!awready) @(negedge clk);
      @(negedge clk);
      // wready follows the address transfer by one cycle
      if (wready !== 1'b1) report_mismatch("wready", 64'(wready), 64'(1));
      awvalid = 1'b0;
      wvalid  = 1'b1;
      wdata   = t.wdata;
      wstrb   = t.strb;
      wlast   = 1'b1;
      while (!wready) @(negedge clk);
      @(negedge clk);
      wvalid = 1'b0;
      wlast  = 1'b0;
      while (!bvalid) @(negedge clk);
      got_id   = bid;
      got_resp = bresp;
      // Response must hold while bready is withheld
      repeat (stall) begin
         @(negedge clk);
         if (!bvalid) begin
            $display("bvalid dropped at %0d ns before bready was given", $time);
            errors++;
         end
         if (bid !== got_id) report_mismatch("bid", 64'(bid), 64'(got_id));
         if (bresp !== got_resp) report_mismatch("bresp", 64'(bresp), 64'(got_resp));
      end
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      if (got_id !== t.id) report_mismatch("bid", 64'(got_id), 64'(t.id));
      if (got_resp !== t.resp) report_mismatch("bresp", 64'(got_resp), 64'(t.resp));
   endtask

   task automatic run_read(input txn_t t);
      tid_t        got_id;
      resp_t       got_resp;
      data_t       got_data;
      logic [31:0] stall;
      stall = random_bits(2);
      @(negedge clk);
      arvalid = 1'b1;
      arid    = t.id;
      araddr  = t.addr;
      arlen   = t.len;
      arsize  = t.size;
      arburst = t.burst;
      while (!arready) @(negedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid) begin
         if (rlast !== 1'b0) report_mismatch("rlast", 64'(rlast), 64'(0));
         @(negedge clk);
      end
      got_id   = rid;
      got_resp = rresp;
      got_data = rdata;
      if (rlast !== 1'b1) report_mismatch("rlast", 64'(rlast), 64'(1));
      repeat (stall) begin
         @(negedge clk);
         if (!rvalid) begin
            $display("rvalid dropped at %0d ns before rready was given", $time);
            errors++;
         end
         if (rid !== got_id) report_mismatch("rid", 64'(rid), 64'(got_id));
         if (rresp !== got_resp) report_mismatch("rresp", 64'(rresp), 64'(got_resp));
         if (rdata !== got_data) report_mismatch("rdata", rdata, got_data);
         if (rlast !== 1'b1) report_mismatch("rlast", 64'(rlast), 64'(1));
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      if (got_id !== t.id) report_mismatch("rid", 64'(got_id), 64'(t.id));
      if (got_resp !== t.resp) report_mismatch("rresp", 64'(got_resp), 64'(t.resp));
      if (got_data !== t.rdata) report_mismatch("rdata", got_data, t.rdata);
   endtask

   // --------------------
   // Timeout and main sequence
   // --------------------
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      init_inputs();
      load_golden();
      if (txns.size() == 0) begin
         $display("The golden file holds no transactions");
         errors++;
      end
      check_reset();
      foreach (txns[i]) begin
         if (txns[i].op == "W") begin
            run_write(txns[i]);
         end else if (txns[i].op == "R") begin
            run_read(txns[i]);
         end else begin
            $display("Golden transaction %0d has an unknown operation", i);
            errors++;
         end
      end
      repeat (2) @(negedge clk);
      $display("Transactions: %0d, errors: %0d", txns.size(), errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/csr_golden.txt
# op id addr size len burst wstrb wdata resp rdata, all fields in hex
# size is the AXI code (2 = 4 bytes, 3 = 8 bytes), resp 0 = OKAY, 2 = SLVERR
R 1 0000 3 00 0 00 0000000000000000 0 00010002c5a00001
W 2 0008 3 00 0 ff 1122334455667788 0 0000000000000000
W 3 0010 3 00 0 ff a5a5a5a55a5a5a5a 0 0000000000000000
R 4 0008 3 00 0 00 0000000000000000 0 1122334455667788
R 5 0010 3 00 0 00 0000000000000000 0 a5a5a5a55a5a5a5a
W 6 0008 2 00 0 0f 00000000deadbeef 0 0000000000000000
W 7 000c 2 00 0 f0 cafef00d00000000 0 0000000000000000
R 8 0008 3 00 0 00 0000000000000000 0 cafef00ddeadbeef
W 9 0010 2 00 0 0f 0000000001234567 0 0000000000000000
R a 0010 3 00 0 00 0000000000000000 0 a5a5a5a501234567
R b 0008 2 00 0 00 0000000000000000 0 00000000deadbeef
R c 000c 2 00 0 00 0000000000000000 0 cafef00ddeadbeef
W d 0008 3 01 0 ff ffffffffffffffff 2 0000000000000000
W e 0008 3 00 1 ff ffffffffffffffff 2 0000000000000000
W f 0008 1 00 0 ff ffffffffffffffff 2 0000000000000000
W 0 0008 4 00 0 ff ffffffffffffffff 2 0000000000000000
W 1 000c 3 00 0 ff ffffffffffffffff 2 0000000000000000
W 2 000a 2 00 0 0f ffffffffffffffff 2 0000000000000000
R 3 0008 3 01 0 00 0000000000000000 2 0000000000000000
R 4 0008 3 00 2 00 0000000000000000 2 0000000000000000
R 5 0008 1 00 0 00 0000000000000000 2 0000000000000000
R 6 0010 4 00 0 00 0000000000000000 2 0000000000000000
R 7 0004 3 00 0 00 0000000000000000 2 0000000000000000
R 8 0008 3 00 0 00 0000000000000000 0 cafef00ddeadbeef
W 9 0008 3 00 0 0f 0000000000000000 0 0000000000000000
W a 000c 2 00 0 0f 1111111111111111 0 0000000000000000
W b 0000 3 00 0 ff 0000000000000000 0 0000000000000000
W c 0100 3 00 0 ff 5555555555555555 0 0000000000000000
R d 0008 3 00 0 00 0000000000000000 0 cafef00ddeadbeef
R e 0000 3 00 0 00 0000000000000000 0 00010002c5a00001
R f 0100 3 00 0 00 0000000000000000 0 0000000000000000
R 0 0018 3 00 0 00 0000000000000000 0 0000000000000000
R 1 0010 3 00 0 00 0000000000000000 0 a5a5a5a501234567

//--- vlog.f
design/csr_pkg.sv
design/axi_mmio_if.sv
design/csr_bus_if.sv
design/axi_csr_slave.sv
design/csr_regfile.sv
design/csr_subsystem_top.sv
verif/clk_gen.sv
verif/tb_csr_subsystem.sv

//--- Makefile
# Verilator build and run of the CSR subsystem testbench

TOP = tb_csr_subsystem

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
